//--- all.f
+incdir+.
cpu_pkg.sv
ctrl_if.sv
control_decode.sv
micro_sequencer.sv
alu.sv
bus_arbiter.sv
datapath.sv
cpu_top.sv
tb_cpu.sv

//--- alu.sv
// ##############################
// ALU
// Zero, invert, add or AND
// ##############################
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::word_t x,
    input  cpu_pkg::word_t y,
    ctrl_if.alu            ctl,
    output cpu_pkg::word_t result,
    output logic           zero,
    output logic           neg,
    output logic           carry
);

    cpu_pkg::word_t x_e, y_e;  // After enable
    cpu_pkg::word_t x_n, y_n;  // After optional invert
    cpu_pkg::word_t core;      // Add or AND
    logic [16:0]    sum;       // Extra bit is carry out

    always_comb begin
        // Operand with EX/EY clear reads as zero
        x_e = ctl.alu_fn[5] ? x : '0;
        y_e = ctl.alu_fn[3] ? y : '0;
        x_n = ctl.alu_fn[4] ? ~x_e : x_e;   // NX
        y_n = ctl.alu_fn[2] ? ~y_e : y_e;   // NY

        sum  = {1'b0, x_n} + {1'b0, y_n};
        core = ctl.alu_fn[1] ? sum[15:0] : (x_n & y_n);

        result = ctl.alu_fn[0] ? ~core : core; // NO
    end

    // Flags on the final result
    assign zero  = (result == '0);
    assign neg   = result[15];
    assign carry = ctl.alu_fn[1] && sum[16];  // Only meaningful on add

endmodule

//--- bus_arbiter.sv
// ##############################
// Bus arbiter
// One driver onto the shared bus
// ##############################
`timescale 1ns/1ns
`include "cpu_defines.svh"

module bus_arbiter (
    ctrl_if.arbiter        ctl,
    input  cpu_pkg::word_t pc_val,
    input  cpu_pkg::word_t ir_val,
    input  cpu_pkg::word_t ram_val,
    input  cpu_pkg::word_t x_val,
    input  cpu_pkg::word_t y_val,
    input  cpu_pkg::word_t dev_val,
    input  cpu_pkg::word_t alu_val,
    output cpu_pkg::word_t bus,
    output logic           dev_rd
);

    always_comb begin
        if (ctl.alu_out) begin
            bus = alu_val;  // Source field holds ALU bits here
        end else begin
            case (ctl.src_sel)
                `CPU_SRC_PC:  bus = pc_val;
                `CPU_SRC_IRH: bus = {8'h00, ir_val[15:8]};
                `CPU_SRC_IRL: bus = {8'h00, ir_val[7:0]};  // Jump target path
                `CPU_SRC_RAM: bus = ram_val;
                `CPU_SRC_X:   bus = x_val;
                `CPU_SRC_Y:   bus = y_val;
                `CPU_SRC_DEV: bus = dev_val;
                default:      bus = '0;  // Nobody drives
            endcase
        end
    end

    assign dev_rd = !ctl.alu_out && (ctl.src_sel == `CPU_SRC_DEV);

    // Every selected peer must hold a known value
    a_bus_known: assert property (@(posedge ctl.clk) disable iff (ctl.reset)
        !$isunknown(bus));

endmodule

//--- control_decode.sv
// ##############################
// Control decoder
// Microinstruction to strobes
// ##############################
`timescale 1ns/1ns
`include "cpu_defines.svh"

// Field map
//  15     ALU drives bus
//  14:12  alu ? EX,NX,EY : source code
//  11     alu ? NY : return to fetch
//  10     alu ? F  : PC increment
//  9      alu ? NO : unused
//  8:6    sink code, 0 is nobody
//  5:2    JC JZ JGT JLT
//  1:0    unused

module control_decode (
    input  cpu_pkg::uinstr_t uinstr,
    ctrl_if.decoder          ctl
);

    logic       alu_drv;  // Bit 15
    logic [2:0] dst;      // Raw sink code

    assign alu_drv = uinstr[15];
    assign dst     = uinstr[8:6];

    // Function bits overlap the source field
    // Harmless: ALU has no side effect unless it drives
    assign ctl.alu_out = alu_drv;
    assign ctl.alu_fn  = uinstr[14:9];

    // Source decode is gated by the ALU drive flag
    assign ctl.src_sel = alu_drv ? `CPU_SRC_NONE : uinstr[14:12];

    assign ctl.ret    = !alu_drv && uinstr[11];
    assign ctl.pc_inc = !alu_drv && uinstr[10];

    // Sink decode, one-hot
    assign ctl.mar_in     = (dst == `CPU_DST_MAR);
    assign ctl.ir_in      = (dst == `CPU_DST_IR);
    assign ctl.ram_in     = (dst == `CPU_DST_RAM);
    assign ctl.x_in       = (dst == `CPU_DST_X);
    assign ctl.y_in       = (dst == `CPU_DST_Y);
    assign ctl.dev_in_sel = (dst == `CPU_DST_DEV);

    // Jump condition strobes
    assign ctl.jc  = uinstr[5];
    assign ctl.jz  = uinstr[4];
    assign ctl.jgt = uinstr[3];
    assign ctl.jlt = uinstr[2];

endmodule

//--- cpu_defines.svh
// ##############################
// CPU shared constants
// Widths, bus codes and opcodes
// ##############################
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define CPU_WIDTH  16  // Data and bus width
`define CPU_ADDR_W 8   // RAM address width
`define CPU_STEPS  8   // Microsteps per instruction

// Bus source codes, uinstr[14:12]
`define CPU_SRC_NONE 3'd0
`define CPU_SRC_PC   3'd1
`define CPU_SRC_IRH  3'd2
`define CPU_SRC_IRL  3'd3
`define CPU_SRC_RAM  3'd4
`define CPU_SRC_X    3'd5
`define CPU_SRC_Y    3'd6
`define CPU_SRC_DEV  3'd7

// Bus sink codes, uinstr[8:6], code 7 spare
`define CPU_DST_NONE 3'd0
`define CPU_DST_MAR  3'd1
`define CPU_DST_IR   3'd2
`define CPU_DST_RAM  3'd3
`define CPU_DST_X    3'd4
`define CPU_DST_Y    3'd5
`define CPU_DST_DEV  3'd6

// Opcodes in IR[15:8], operand in IR[7:0]
`define CPU_OP_IN_X    8'h01
`define CPU_OP_IN_Y    8'h02
`define CPU_OP_OUT_X   8'h03
`define CPU_OP_JMP     8'h04  // PC <= IR[7:0]
`define CPU_OP_JZ      8'h05  // PC <= IR[7:0] if zero flag
`define CPU_OP_HALT    8'h0F
`define CPU_OP_ALU_PFX 2'b01  // {01, fn[5:0]}: ALU result to device

`endif

//--- cpu_pkg.sv
// ##############################
// CPU types
// Words, microcode fields, state
// ##############################
`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`CPU_WIDTH-1:0]  word_t;   // Bus word
    typedef logic [`CPU_ADDR_W-1:0] addr_t;   // RAM address
    typedef logic [15:0]            uinstr_t; // Microinstruction
    typedef logic [7:0]             opcode_t; // IR high byte

    // Microstep counter, one instruction at most CPU_STEPS long
    typedef logic [$clog2(`CPU_STEPS)-1:0] step_t;

    // ALU function bits, MSB first
    // [5] EX  enable X, else X forced to zero
    // [4] NX  invert X
    // [3] EY  enable Y
    // [2] NY  invert Y
    // [1] F   add when set, AND when clear
    // [0] NO  invert result
    typedef logic [5:0] alu_fn_t;

    // Sequencer state
    typedef enum logic {
        RUN,
        HALTED  // Frozen until reset
    } seq_state_t;

endpackage

//--- cpu_top.sv
// ##############################
// CPU top level
// ##############################
`timescale 1ns/1ns

module cpu_top (
    input  logic           clk,
    input  logic           reset,
    input  logic           load_we,
    input  cpu_pkg::addr_t load_addr,
    input  cpu_pkg::word_t load_data,
    input  cpu_pkg::word_t dev_in,
    output logic           dev_rd,
    output logic           dev_wr,
    output cpu_pkg::word_t dev_out,
    output logic           halted
);

    cpu_pkg::uinstr_t uinstr;
    cpu_pkg::opcode_t opcode;
    cpu_pkg::word_t   bus;
    cpu_pkg::word_t   pc_val, ir_val, ram_val, x_val, y_val;
    cpu_pkg::word_t   alu_res;
    logic             alu_zero, alu_neg, alu_carry;

    ctrl_if u_ctl (.clk(clk), .reset(reset));

    micro_sequencer u_seq (
        .clk(clk), .reset(reset), .opcode(opcode), .ctl(u_ctl),
        .uinstr(uinstr), .halted(halted)
    );

    control_decode u_dec (.uinstr(uinstr), .ctl(u_ctl));

    alu u_alu (
        .x(x_val), .y(y_val), .ctl(u_ctl), .result(alu_res),
        .zero(alu_zero), .neg(alu_neg), .carry(alu_carry)
    );

    bus_arbiter u_arb (
        .ctl(u_ctl), .pc_val(pc_val), .ir_val(ir_val), .ram_val(ram_val),
        .x_val(x_val), .y_val(y_val), .dev_val(dev_in), .alu_val(alu_res),
        .bus(bus), .dev_rd(dev_rd)
    );

    datapath u_dp (
        .clk(clk), .reset(reset), .ctl(u_ctl), .bus(bus),
        .alu_zero(alu_zero), .alu_neg(alu_neg), .alu_carry(alu_carry),
        .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
        .pc_val(pc_val), .ir_val(ir_val), .ram_val(ram_val),
        .x_val(x_val), .y_val(y_val), .opcode(opcode),
        .dev_wr(dev_wr), .dev_out(dev_out)
    );

endmodule

//--- ctrl_if.sv
// ##############################
// Decoded control strobes
// ##############################
`timescale 1ns/1ns

interface ctrl_if (input logic clk, input logic reset);

    logic              alu_out;  // ALU owns the bus
    logic [2:0]        src_sel;  // Bus source, NONE while alu_out
    logic              mar_in, ir_in, ram_in, x_in, y_in, dev_in_sel; // One-hot sinks
    logic              ret;      // Back to fetch next cycle
    logic              pc_inc;
    cpu_pkg::alu_fn_t  alu_fn;
    logic              jc, jz, jgt, jlt;

    modport decoder (output alu_out, src_sel, mar_in, ir_in, ram_in, x_in, y_in,
                     dev_in_sel, ret, pc_inc, alu_fn, jc, jz, jgt, jlt);
    modport arbiter (input clk, reset, alu_out, src_sel);
    modport datapath (input alu_out, mar_in, ir_in, ram_in, x_in, y_in, dev_in_sel,
                      pc_inc, jc, jz, jgt, jlt);
    modport alu (input alu_fn);
    modport sequencer (input ret);

endinterface

//--- datapath.sv
// ##############################
// Datapath
// Registers, RAM, jumps, device port
// ##############################
`timescale 1ns/1ns
`include "cpu_defines.svh"

module datapath (
    input  logic             clk,
    input  logic             reset,
    ctrl_if.datapath         ctl,
    input  cpu_pkg::word_t   bus,
    input  logic             alu_zero,
    input  logic             alu_neg,
    input  logic             alu_carry,
    input  logic             load_we,    // Program load, honored only in reset
    input  cpu_pkg::addr_t   load_addr,
    input  cpu_pkg::word_t   load_data,
    output cpu_pkg::word_t   pc_val,
    output cpu_pkg::word_t   ir_val,
    output cpu_pkg::word_t   ram_val,
    output cpu_pkg::word_t   x_val,
    output cpu_pkg::word_t   y_val,
    output cpu_pkg::opcode_t opcode,
    output logic             dev_wr,
    output cpu_pkg::word_t   dev_out
);

    cpu_pkg::addr_t pc, mar;
    cpu_pkg::word_t ir, x, y;
    cpu_pkg::word_t dev_q;       // Last word sent to the device
    logic           z_q, n_q, c_q;
    logic           cond_any;    // Any flag condition requested
    logic           jump_taken;

    cpu_pkg::word_t mem [2**`CPU_ADDR_W];

    // JC alone is unconditional; with a condition it also fires on carry
    assign cond_any   = ctl.jz | ctl.jgt | ctl.jlt;
    assign jump_taken = (ctl.jz & z_q)
                      | (ctl.jgt & ~z_q & ~n_q)
                      | (ctl.jlt & n_q)
                      | (ctl.jc & (~cond_any | c_q));

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            pc  <= '0;
            z_q <= 1'b0;
            n_q <= 1'b0;
            c_q <= 1'b0;
        end else begin
            if (jump_taken)
                pc <= bus[`CPU_ADDR_W-1:0];  // Jump wins over increment
            else if (ctl.pc_inc)
                pc <= pc + 1'b1;
            if (ctl.alu_out) begin  // Flags follow every ALU drive
                z_q <= alu_zero;
                n_q <= alu_neg;
                c_q <= alu_carry;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (ctl.mar_in)     mar   <= bus[`CPU_ADDR_W-1:0];
        if (ctl.ir_in)      ir    <= bus;
        if (ctl.x_in)       x     <= bus;
        if (ctl.y_in)       y     <= bus;
        if (ctl.dev_in_sel) dev_q <= bus;
    end

    // RAM, loader port owns it during reset
    always_ff @(posedge clk) begin
        if (reset) begin
            if (load_we)
                mem[load_addr] <= load_data;
        end else if (ctl.ram_in) begin
            mem[mar] <= bus;
        end
    end

    assign ram_val = mem[mar];  // Async read
    assign pc_val  = {8'h00, pc};
    assign ir_val  = ir;
    assign x_val   = x;
    assign y_val   = y;
    assign opcode  = ir[15:8];

    // Device write, bus value visible in the strobe cycle then held
    assign dev_wr  = ctl.dev_in_sel;
    assign dev_out = ctl.dev_in_sel ? bus : dev_q;

    a_load_in_reset: assert property (@(posedge clk) load_we |-> reset);

endmodule

//--- micro_sequencer.sv
// ##############################
// Micro-sequencer
// Microcode ROM, step counter, halt
// ##############################
`timescale 1ns/1ns
`include "cpu_defines.svh"

module micro_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::opcode_t  opcode,
    ctrl_if.sequencer         ctl,
    output cpu_pkg::uinstr_t  uinstr,
    output logic              halted
);

    cpu_pkg::step_t      step;
    cpu_pkg::seq_state_t state;
    cpu_pkg::uinstr_t    rom_word;

    // Plain bus transfer word
    function automatic cpu_pkg::uinstr_t mk_ctl(input logic [2:0] src, input logic [2:0] dst,
                                                input logic rt, input logic pinc,
                                                input logic [3:0] jmp);
        mk_ctl = {1'b0, src, rt, pinc, 1'b0, dst, jmp, 2'b00};
    endfunction

    // ALU drives the bus, no ret possible in the same word
    function automatic cpu_pkg::uinstr_t mk_alu(input cpu_pkg::alu_fn_t fn,
                                                input logic [2:0] dst);
        mk_alu = {1'b1, fn, dst, 4'b0000, 2'b00};
    endfunction

    // ROM by opcode and step
    always_comb begin
        rom_word = '0;
        if (state == cpu_pkg::HALTED) begin
            rom_word = '0;  // No driver, no sink
        end else if (step == 3'd0) begin
            rom_word = mk_ctl(`CPU_SRC_PC, `CPU_DST_MAR, 1'b0, 1'b0, 4'b0000);
        end else if (step == 3'd1) begin
            rom_word = mk_ctl(`CPU_SRC_RAM, `CPU_DST_IR, 1'b0, 1'b1, 4'b0000);
        end else if (opcode[7:6] == `CPU_OP_ALU_PFX) begin
            if (step == 3'd2)
                rom_word = mk_alu(opcode[5:0], `CPU_DST_DEV); // Result to device
            else
                rom_word = mk_ctl(`CPU_SRC_NONE, `CPU_DST_NONE, 1'b1, 1'b0, 4'b0000);
        end else begin
            case (opcode)
                `CPU_OP_IN_X:  rom_word = mk_ctl(`CPU_SRC_DEV, `CPU_DST_X, 1'b1, 1'b0, 4'b0000);
                `CPU_OP_IN_Y:  rom_word = mk_ctl(`CPU_SRC_DEV, `CPU_DST_Y, 1'b1, 1'b0, 4'b0000);
                `CPU_OP_OUT_X: rom_word = mk_ctl(`CPU_SRC_X, `CPU_DST_DEV, 1'b1, 1'b0, 4'b0000);
                `CPU_OP_JMP:   rom_word = mk_ctl(`CPU_SRC_IRL, `CPU_DST_NONE, 1'b1, 1'b0, 4'b1000);
                `CPU_OP_JZ:    rom_word = mk_ctl(`CPU_SRC_IRL, `CPU_DST_NONE, 1'b1, 1'b0, 4'b0100);
                `CPU_OP_HALT:  rom_word = '0;  // State change does the work
                default:       rom_word = mk_ctl(`CPU_SRC_NONE, `CPU_DST_NONE, 1'b1, 1'b0, 4'b0000);
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cpu_pkg::RUN;
            step  <= '0;
        end else if (state == cpu_pkg::RUN) begin
            if (step == 3'd2 && opcode == `CPU_OP_HALT)
                state <= cpu_pkg::HALTED;  // Step stays frozen from here
            else
                step <= ctl.ret ? '0 : step + 1'b1;
        end
    end

    assign uinstr = rom_word;
    assign halted = (state == cpu_pkg::HALTED);

    // Last step must hand back to fetch through the decoder's ret
    a_step_ret: assert property (@(posedge clk) disable iff (reset)
        (state == cpu_pkg::RUN && step == 3'(`CPU_STEPS - 1)) |-> ctl.ret);

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the CPU testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_cpu -f all.f -o sim_cpu \
    && ./obj_dir/sim_cpu | tee sim.log \
    && grep -qx "Test passed" sim.log \
    || { echo "CPU simulation did not pass"; exit 1; }

exit 0

//--- tb_cpu.sv
// ##############################
// CPU testbench
// Table of programs, device model
// ##############################
`timescale 1ns/1ns
`include "cpu_defines.svh"

module tb_cpu;

    localparam int NROWS       = 12;
    localparam int CYCLE_LIMIT = 60 * NROWS;  // 60 cycles per row
    localparam int PK_ALU  = 0;  // IN X, IN Y, ALU to device, HALT
    localparam int PK_PASS = 1;  // IN X, OUT X, HALT
    localparam int PK_JZ   = 2;  // ALU result, then JZ over an OUT X
    localparam int PK_JMP  = 3;  // IN X, JMP over an OUT X, OUT X

    logic           clk, reset, load_we;
    cpu_pkg::addr_t load_addr;
    cpu_pkg::word_t load_data, dev_in, dev_out;
    logic           dev_rd, dev_wr, halted;

    // Stimulus table, one row per test
    string            t_name [NROWS];
    int               t_kind [NROWS];
    cpu_pkg::alu_fn_t t_fn   [NROWS];
    bit               t_rand [NROWS];  // Operands from the LFSR
    cpu_pkg::word_t   t_x    [NROWS];
    cpu_pkg::word_t   t_y    [NROWS];
    cpu_pkg::word_t   t_exp  [NROWS];  // First output, fixed rows only
    int               t_cnt  [NROWS];  // dev_wr pulses before halt

    int             n_rows, errors, tests_failed, cycles;
    logic [15:0]    lfsr_state;
    cpu_pkg::word_t prog [$];  // Words for the load port
    cpu_pkg::word_t ops  [$];  // Device input, in read order
    cpu_pkg::word_t outs [$];  // Captured device writes

    cpu_top u_cpu_top (
        .clk(clk), .reset(reset), .load_we(load_we), .load_addr(load_addr),
        .load_data(load_data), .dev_in(dev_in), .dev_rd(dev_rd), .dev_wr(dev_wr),
        .dev_out(dev_out), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // Hard stop if a program never halts
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the CPU never finished the tests", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_word(output cpu_pkg::word_t w);
        cpu_pkg::word_t acc;
        acc = '0;
        for (int b = 0; b < 16; b++) begin
            lfsr_state = lfsr_next(lfsr_state);  // One step per bit
            acc = {acc[14:0], lfsr_state[0]};
        end
        w = acc;
    endtask

    // Reference: zero, invert, add or AND, invert result
    function automatic cpu_pkg::word_t alu_model(input cpu_pkg::alu_fn_t fn,
                                                 input cpu_pkg::word_t x,
                                                 input cpu_pkg::word_t y);
        cpu_pkg::word_t a, b, r;
        a = '0;
        b = '0;
        if (fn[5]) a = x;   // EX
        if (fn[4]) a = ~a;  // NX
        if (fn[3]) b = y;   // EY
        if (fn[2]) b = ~b;  // NY
        if (fn[1])
            r = a + b;      // Carry out dropped
        else
            r = a & b;
        if (fn[0]) r = ~r;  // NO
        return r;
    endfunction

    function automatic cpu_pkg::word_t first_output(input int kind, input cpu_pkg::alu_fn_t fn,
                                                    input cpu_pkg::word_t x,
                                                    input cpu_pkg::word_t y);
        if (kind == PK_ALU || kind == PK_JZ)
            return alu_model(fn, x, y);
        return x;  // OUT X programs echo the input
    endfunction

    task automatic compare(input string label, input cpu_pkg::word_t exp_val,
                           input cpu_pkg::word_t act_val);
        if (exp_val !== act_val) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", label, exp_val, act_val);
        end
    endtask

    task automatic add_row(input string name, input int kind, input cpu_pkg::alu_fn_t fn,
                           input bit rnd, input cpu_pkg::word_t x, input cpu_pkg::word_t y,
                           input cpu_pkg::word_t exp_val, input int cnt);
        t_name[n_rows] = name;
        t_kind[n_rows] = kind;
        t_fn[n_rows]   = fn;
        t_rand[n_rows] = rnd;
        t_x[n_rows]    = x;
        t_y[n_rows]    = y;
        t_exp[n_rows]  = exp_val;
        t_cnt[n_rows]  = cnt;
        n_rows++;
    endtask

    task automatic fill_table();
        // name          kind     EXNXEYNYFNO rnd   x         y         expect    cnt
        add_row("add",          PK_ALU,  6'b101010, 1'b1, 16'h0000, 16'h0000, 16'h0000, 1);
        add_row("and",          PK_ALU,  6'b101000, 1'b1, 16'h0000, 16'h0000, 16'h0000, 1);
        add_row("x_minus_y",    PK_ALU,  6'b111011, 1'b1, 16'h0000, 16'h0000, 16'h0000, 1);
        add_row("neg_x",        PK_ALU,  6'b100111, 1'b1, 16'h0000, 16'h0000, 16'h0000, 1);
        add_row("const_zero",   PK_ALU,  6'b000010, 1'b1, 16'h0000, 16'h0000, 16'h0000, 1);
        add_row("const_one",    PK_ALU,  6'b010111, 1'b1, 16'h0000, 16'h0000, 16'h0000, 1);
        add_row("add_wrap",     PK_ALU,  6'b101010, 1'b0, 16'hFFFF, 16'h0001, 16'h0000, 1);
        add_row("sub_fixed",    PK_ALU,  6'b111011, 1'b0, 16'h0010, 16'h0003, 16'h000D, 1);
        add_row("pass_x",       PK_PASS, 6'b000000, 1'b1, 16'h0000, 16'h0000, 16'h0000, 1);
        add_row("jz_taken",     PK_JZ,   6'b000010, 1'b0, 16'h0005, 16'h0009, 16'h0000, 1);
        add_row("jz_not_taken", PK_JZ,   6'b101010, 1'b0, 16'h0003, 16'h0004, 16'h0007, 2);
        add_row("jmp_over_out", PK_JMP,  6'b000000, 1'b0, 16'h1234, 16'h0000, 16'h1234, 1);
    endtask

    task automatic build_program(input int kind, input cpu_pkg::alu_fn_t fn,
                                 input cpu_pkg::word_t x, input cpu_pkg::word_t y);
        prog.delete();
        ops.delete();
        ops.push_back(x);
        prog.push_back({`CPU_OP_IN_X, 8'h00});
        case (kind)
            PK_ALU, PK_JZ: begin
                ops.push_back(y);
                prog.push_back({`CPU_OP_IN_Y, 8'h00});
                prog.push_back({`CPU_OP_ALU_PFX, fn, 8'h00});
                if (kind == PK_JZ) begin
                    prog.push_back({`CPU_OP_JZ, 8'd5});  // Skips the OUT at 4
                    prog.push_back({`CPU_OP_OUT_X, 8'h00});
                end
            end
            PK_PASS: prog.push_back({`CPU_OP_OUT_X, 8'h00});
            default: begin
                prog.push_back({`CPU_OP_JMP, 8'd3});
                prog.push_back({`CPU_OP_OUT_X, 8'h00});  // Never reached
                prog.push_back({`CPU_OP_OUT_X, 8'h00});
            end
        endcase
        prog.push_back({`CPU_OP_HALT, 8'h00});
    endtask

    task automatic run_row(input int r);
        cpu_pkg::word_t x, y, exp_val;
        int             errs_at_start, rd_count;
        bit             rd_pending, done;
        string          name;
        name          = t_name[r];
        x             = t_x[r];
        y             = t_y[r];
        errs_at_start = errors;
        if (t_rand[r]) begin
            rand_word(x);
            rand_word(y);
        end
        exp_val = t_rand[r] ? first_output(t_kind[r], t_fn[r], x, y) : t_exp[r];
        build_program(t_kind[r], t_fn[r], x, y);
        outs.delete();

        // Reset window doubles as the program load
        @(posedge clk);
        #1;
        reset  = 1'b1;
        dev_in = ops[0];
        for (int i = 0; i < 10; i++) begin
            load_we   = (i < prog.size());
            load_addr = cpu_pkg::addr_t'(i);
            load_data = (i < prog.size()) ? prog[i] : '0;
            @(negedge clk);
            if (i == 9) begin  // Idle outputs before the program starts
                compare({name, " dev_rd idle"}, 16'd0, {15'd0, dev_rd});
                compare({name, " dev_wr idle"}, 16'd0, {15'd0, dev_wr});
                compare({name, " halted idle"}, 16'd0, {15'd0, halted});
            end
            @(posedge clk);
            #1;
        end
        load_we = 1'b0;
        reset   = 1'b0;

        rd_count   = 0;
        rd_pending = 1'b0;
        done       = 1'b0;
        while (!done) begin
            @(negedge clk);  // Outputs settled mid cycle
            if (dev_rd) rd_pending = 1'b1;
            if (dev_wr) outs.push_back(dev_out);
            if (halted) done = 1'b1;
            @(posedge clk);
            #1;
            if (rd_pending) begin  // Operand consumed at this edge
                rd_count++;
                dev_in     = (rd_count < ops.size()) ? ops[rd_count] : '0;
                rd_pending = 1'b0;
            end
        end

        // Halt is sticky and quiet
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            compare({name, " halted held"}, 16'd1, {15'd0, halted});
            compare({name, " dev_wr after halt"}, 16'd0, {15'd0, dev_wr});
            @(posedge clk);
            #1;
        end

        compare({name, " dev_rd count"}, cpu_pkg::word_t'(ops.size()),
                cpu_pkg::word_t'(rd_count));
        compare({name, " dev_wr count"}, cpu_pkg::word_t'(t_cnt[r]),
                cpu_pkg::word_t'(outs.size()));
        if (outs.size() > 0)
            compare({name, " first output"}, exp_val, outs[0]);
        if (outs.size() > 1)
            compare({name, " last output"}, x, outs[outs.size() - 1]);  // Trailing OUT X

        if (errors == errs_at_start) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s", name);
        end
    endtask

    initial begin
        reset        = 1'b1;
        load_we      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        dev_in       = '0;
        errors       = 0;
        tests_failed = 0;
        n_rows       = 0;
        cycles       = 0;
        lfsr_state   = 16'd18691;  // LFSR seed
        fill_table();
        for (int r = 0; r < n_rows; r++)
            run_row(r);
        $display("Ran %0d tests: %0d passed, %0d failed, %0d mismatches",
                 n_rows, n_rows - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule
